//--- logic/poly_cfg_pkg.sv
package poly_cfg_pkg;

   // token and result widths
   localparam int word_w = 16;
   localparam int acc_w = 32;                       // results wrap modulo 2^32

   // coefficient storage
   localparam int slot_count = 8;
   localparam int max_order = 7;                    // so each slot holds eight coefficients
   localparam int slot_w = $clog2(slot_count);
   localparam int index_w = $clog2(max_order + 1);

   localparam int queue_depth = 64;                 // entries in each token queue

endpackage

//--- logic/poly_cmd_pkg.sv
package poly_cmd_pkg;

   // ##########################################################
   // opcodes and firing modes
   // ##########################################################
   localparam int op_w = 8;
   localparam logic [op_w-1:0] op_stp = 8'd0;
   localparam logic [op_w-1:0] op_evp = 8'd1;
   localparam logic [op_w-1:0] op_evb = 8'd2;
   localparam logic [op_w-1:0] op_rst = 8'd3;
   localparam logic [op_w-1:0] op_none = 8'd255;    // instr after reset or RST

   localparam logic [1:0] mode_setup = 2'd0;
   localparam logic [1:0] mode_instr = 2'd1;

   // command word is opcode in 15:8, slot in 7:5 and count in 4:0
   localparam int op_lsb = 8;
   localparam int slot_lsb = 5;
   localparam int cnt_w = 5;                        // N for STP, b for EVB

   // ##########################################################
   // status codes returned in the low half of the status word
   // ##########################################################
   localparam int code_w = 16;
   localparam logic [code_w-1:0] st_ok = 16'd0;
   localparam logic [code_w-1:0] st_bad_order = 16'd1;
   localparam logic [code_w-1:0] st_empty_slot = 16'd2;
   localparam logic [code_w-1:0] st_zero_block = 16'd3;
   localparam logic [code_w-1:0] st_bad_opcode = 16'd4;

endpackage

//--- logic/coef_bus_if.sv
`timescale 1ns/1ps

interface coef_bus_if;

   // write side driven while a polynomial is stored
   logic wr_en;
   logic [poly_cfg_pkg::slot_w-1:0] wr_slot;
   logic [poly_cfg_pkg::index_w-1:0] wr_index;
   logic [poly_cfg_pkg::word_w-1:0] wr_data;
   logic set_order;
   logic [poly_cfg_pkg::index_w-1:0] order_in;

   // on the read side rd_data follows the address by one cycle
   logic [poly_cfg_pkg::slot_w-1:0] rd_slot;
   logic [poly_cfg_pkg::index_w-1:0] rd_index;
   logic [poly_cfg_pkg::word_w-1:0] rd_data;
   logic [poly_cfg_pkg::index_w-1:0] rd_order;
   logic rd_valid;

   modport writer (output wr_en, wr_slot, wr_index, wr_data, set_order, order_in);
   modport reader (output rd_slot, rd_index, input rd_data, rd_order, rd_valid);
   modport store (input wr_en, wr_slot, wr_index, wr_data, set_order, order_in,
                  input rd_slot, rd_index, output rd_data, rd_order, rd_valid);

endinterface

//--- logic/token_queue.sv
`timescale 1ns/1ps

module token_queue
#(
   parameter int depth = 64
)
(
   input  logic clk,
   input  logic rst,
   input  logic push,
   input  logic [poly_cfg_pkg::word_w-1:0] push_token,
   input  logic pop_a,
   input  logic pop_b,
   output logic avail,
   output logic [poly_cfg_pkg::word_w-1:0] token
);

   logic [poly_cfg_pkg::word_w-1:0] mem [depth];
   logic [$clog2(depth)-1:0] wr_ptr;
   logic [$clog2(depth)-1:0] rd_ptr;
   logic [$clog2(depth):0] used;
   logic do_push;
   logic do_pop;

   assign avail = (used != '0);
   assign do_pop = (pop_a | pop_b) & avail;         // only one reader runs at a time
   assign do_push = push & (int'(used) < depth);    // a full queue drops the token

   // depth is a power of two, so both pointers wrap on their own
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10: used <= used + 1'b1;
            2'b01: used <= used - 1'b1;
            default: used <= used;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_token;
      if (do_pop)
         token <= mem[rd_ptr];                      // head is valid the cycle after the pop
   end

endmodule

//--- logic/coef_store.sv
`timescale 1ns/1ps

module coef_store
(
   input logic clk,
   input logic rst,
   coef_bus_if.store bus,
   input logic clear
);

   // one row of max_order+1 words per slot addressed as {slot, index}
   logic [poly_cfg_pkg::word_w-1:0] coef_mem
      [poly_cfg_pkg::slot_count * (poly_cfg_pkg::max_order + 1)];
   logic [poly_cfg_pkg::index_w-1:0] order_r [poly_cfg_pkg::slot_count];
   logic [poly_cfg_pkg::slot_count-1:0] valid_r;

   always_ff @(posedge clk)
   begin
      if (bus.wr_en)
         coef_mem[{bus.wr_slot, bus.wr_index}] <= bus.wr_data;
      if (bus.set_order)
         order_r[bus.wr_slot] <= bus.order_in;
      bus.rd_data <= coef_mem[{bus.rd_slot, bus.rd_index}];
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         valid_r <= '0;
      else if (clear)
         valid_r <= '0;                             // RST drops every stored polynomial
      else if (bus.set_order)
         valid_r[bus.wr_slot] <= 1'b1;
   end

   // order and valid are looked up without delay
   assign bus.rd_order = order_r[bus.rd_slot];
   assign bus.rd_valid = valid_r[bus.rd_slot];

endmodule

//--- logic/command_decoder.sv
`timescale 1ns/1ps

module command_decoder
(
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic clear,
   input  logic cmd_avail,
   output logic cmd_pop,
   input  logic [poly_cfg_pkg::word_w-1:0] cmd_token,
   output logic [poly_cmd_pkg::op_w-1:0] instr,
   output logic [poly_cfg_pkg::slot_w-1:0] slot,
   output logic [poly_cmd_pkg::cnt_w-1:0] count,
   output logic done
);

   localparam logic [1:0] s_idle = 2'd0;
   localparam logic [1:0] s_wait = 2'd1;
   localparam logic [1:0] s_latch = 2'd2;

   logic [1:0] state;

   assign cmd_pop = (state == s_wait) && cmd_avail;
   assign done = (state == s_latch);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         state <= s_idle;
      else
         case (state)
            s_idle:
               if (start)
                  state <= s_wait;
            s_wait:
               if (cmd_avail)
                  state <= s_latch;                 // popped word shows up next cycle
            default:
               state <= s_idle;
         endcase
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         instr <= poly_cmd_pkg::op_none;
      else if (clear)
         instr <= poly_cmd_pkg::op_none;
      else if (state == s_latch)
         instr <= cmd_token[poly_cmd_pkg::op_lsb +: poly_cmd_pkg::op_w];
   end

   always_ff @(posedge clk)
   begin
      if (state == s_latch)
      begin
         slot <= cmd_token[poly_cmd_pkg::slot_lsb +: poly_cfg_pkg::slot_w];
         count <= cmd_token[poly_cmd_pkg::cnt_w-1:0];
      end
   end

endmodule

//--- logic/poly_setup.sv
`timescale 1ns/1ps

module poly_setup
(
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic [poly_cfg_pkg::slot_w-1:0] slot,
   input  logic [poly_cmd_pkg::cnt_w-1:0] count,
   input  logic data_avail,
   output logic data_pop,
   input  logic [poly_cfg_pkg::word_w-1:0] data_token,
   coef_bus_if.writer coef,
   output logic [poly_cmd_pkg::code_w-1:0] status,
   output logic done
);

   localparam logic [1:0] s_idle = 2'd0;
   localparam logic [1:0] s_pop = 2'd1;
   localparam logic [1:0] s_write = 2'd2;
   localparam logic [1:0] s_fin = 2'd3;

   logic [1:0] state;
   logic [poly_cfg_pkg::index_w-1:0] index;         // counts down from N to 0

   assign data_pop = (state == s_pop) && data_avail;
   assign coef.wr_en = (state == s_write);
   assign coef.wr_slot = slot;
   assign coef.wr_index = index;
   assign coef.wr_data = data_token;
   // the slot only turns valid once every coefficient is in
   assign coef.set_order = (state == s_fin) && (status == poly_cmd_pkg::st_ok);
   assign coef.order_in = count[poly_cfg_pkg::index_w-1:0];
   assign done = (state == s_fin);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state <= s_idle;
         index <= '0;
         status <= poly_cmd_pkg::st_ok;
      end
      else
         case (state)
            s_idle:
               if (start)
               begin
                  index <= count[poly_cfg_pkg::index_w-1:0];
                  if (int'(count) > poly_cfg_pkg::max_order)
                  begin
                     status <= poly_cmd_pkg::st_bad_order;
                     state <= s_fin;                // nothing popped for a bad order
                  end
                  else
                  begin
                     status <= poly_cmd_pkg::st_ok;
                     state <= s_pop;
                  end
               end
            s_pop:
               if (data_avail)
                  state <= s_write;
            s_write:
            begin
               index <= index - 1'b1;
               state <= (index == '0) ? s_fin : s_pop;
            end
            default:
               state <= s_idle;
         endcase
   end

endmodule

//--- logic/poly_eval.sv
`timescale 1ns/1ps

module poly_eval
(
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic [poly_cfg_pkg::slot_w-1:0] slot,
   input  logic [poly_cmd_pkg::cnt_w-1:0] count,
   input  logic block,
   input  logic data_avail,
   output logic data_pop,
   input  logic [poly_cfg_pkg::word_w-1:0] data_token,
   coef_bus_if.reader coef,
   output logic [poly_cfg_pkg::acc_w-1:0] result,
   output logic [poly_cmd_pkg::code_w-1:0] status,
   output logic point_done,
   output logic done
);

   localparam logic [2:0] s_idle = 3'd0;
   localparam logic [2:0] s_pop = 3'd1;
   localparam logic [2:0] s_load = 3'd2;
   localparam logic [2:0] s_mac = 3'd3;
   localparam logic [2:0] s_out = 3'd4;
   localparam logic [2:0] s_err = 3'd5;

   logic [2:0] state;
   logic [poly_cfg_pkg::index_w-1:0] index;
   logic [poly_cmd_pkg::cnt_w-1:0] left;            // x values after the current one
   logic [poly_cfg_pkg::acc_w-1:0] x;
   logic [poly_cfg_pkg::acc_w-1:0] coef_ext;

   assign coef_ext = {{(poly_cfg_pkg::acc_w - poly_cfg_pkg::word_w){1'b0}}, coef.rd_data};
   assign coef.rd_slot = slot;

   // during the accumulate the address runs one step ahead of index
   assign coef.rd_index = (state == s_mac) ? index - 1'b1 : index;
   assign data_pop = (state == s_pop) && data_avail;
   assign point_done = (state == s_out) && (left != '0);
   assign done = ((state == s_out) && (left == '0)) || (state == s_err);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state <= s_idle;
         index <= '0;
         left <= '0;
         status <= poly_cmd_pkg::st_ok;
      end
      else
         case (state)
            s_idle:
               if (start)
               begin
                  left <= block ? count - 1'b1 : '0;
                  if (!coef.rd_valid)
                  begin
                     status <= poly_cmd_pkg::st_empty_slot;
                     state <= s_err;
                  end
                  else if (block && count == '0)
                  begin
                     status <= poly_cmd_pkg::st_zero_block;
                     state <= s_err;
                  end
                  else
                  begin
                     status <= poly_cmd_pkg::st_ok;
                     state <= s_pop;
                  end
               end
            s_pop:
            begin
               index <= coef.rd_order;              // Horner starts at the top coefficient
               if (data_avail)
                  state <= s_load;
            end
            s_load:
               state <= s_mac;
            s_mac:
            begin
               index <= index - 1'b1;
               if (index == '0)
                  state <= s_out;
            end
            s_out:
            begin
               left <= left - 1'b1;
               state <= (left == '0) ? s_idle : s_pop;
            end
            default:
               state <= s_idle;                     // error exit after its done pulse
         endcase
   end

   // ##########################################################
   // Horner datapath computing acc = acc * x + c[i] modulo 2^32
   // ##########################################################
   always_ff @(posedge clk)
   begin
      if (state == s_load)
      begin
         x <= {{(poly_cfg_pkg::acc_w - poly_cfg_pkg::word_w){1'b0}}, data_token};
         result <= '0;
      end
      else if (state == s_mac)
         result <= result * x + coef_ext;
   end

endmodule

//--- logic/firing_fsm.sv
`timescale 1ns/1ps

module firing_fsm
(
   input  logic clk,
   input  logic rst,
   input  logic start,
   input  logic [1:0] next_mode,
   input  logic [poly_cmd_pkg::op_w-1:0] instr,
   input  logic dec_done,
   input  logic setup_done,
   input  logic eval_point,
   input  logic eval_done,
   input  logic [poly_cmd_pkg::code_w-1:0] setup_status,
   input  logic [poly_cmd_pkg::code_w-1:0] eval_status,
   input  logic [poly_cfg_pkg::acc_w-1:0] eval_result,
   output logic dec_start,
   output logic setup_start,
   output logic eval_start,
   output logic eval_block,
   output logic store_clear,
   output logic done,
   output logic result_valid,
   output logic [poly_cfg_pkg::acc_w-1:0] result,
   output logic [poly_cfg_pkg::acc_w-1:0] status
);

   localparam logic [3:0] s_idle = 4'd0;
   localparam logic [3:0] s_get_start = 4'd1;
   localparam logic [3:0] s_get_wait = 4'd2;
   localparam logic [3:0] s_get_fin = 4'd3;
   localparam logic [3:0] s_stp_start = 4'd4;
   localparam logic [3:0] s_stp_wait = 4'd5;
   localparam logic [3:0] s_evp_start = 4'd6;
   localparam logic [3:0] s_evp_wait = 4'd7;
   localparam logic [3:0] s_evb_start = 4'd8;
   localparam logic [3:0] s_evb_wait = 4'd9;
   localparam logic [3:0] s_evb_out = 4'd10;
   localparam logic [3:0] s_rst = 4'd11;
   localparam logic [3:0] s_out = 4'd12;

   logic [3:0] state;
   logic [3:0] next;
   logic [poly_cmd_pkg::code_w-1:0] code;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
         state <= s_idle;
      else
         state <= next;
   end

   // ##########################################################
   // next state
   // ##########################################################
   always_comb
   begin
      next = state;
      case (state)
         s_idle:
            if (start && next_mode == poly_cmd_pkg::mode_setup)
               next = s_get_start;
            else if (start && next_mode == poly_cmd_pkg::mode_instr)
            begin
               case (instr)
                  poly_cmd_pkg::op_stp: next = s_stp_start;
                  poly_cmd_pkg::op_evp: next = s_evp_start;
                  poly_cmd_pkg::op_evb: next = s_evb_start;
                  poly_cmd_pkg::op_rst: next = s_rst;
                  default: next = s_out;            // an unknown opcode is reported straight away
               endcase
            end
         s_get_start: next = s_get_wait;
         s_get_wait:
            if (dec_done)
               next = s_get_fin;
         s_stp_start: next = s_stp_wait;
         s_stp_wait:
            if (setup_done)
               next = s_out;
         s_evp_start: next = s_evp_wait;
         s_evp_wait:
            if (eval_done)
               next = s_out;
         s_evb_start: next = s_evb_wait;
         s_evb_wait:
            if (eval_done)
               next = s_out;                        // last result goes out with done
            else if (eval_point)
               next = s_evb_out;
         s_evb_out: next = s_evb_wait;
         default: next = s_idle;
      endcase
   end

   // ##########################################################
   // strobes and output word selection
   // ##########################################################
   assign dec_start = (state == s_get_start);
   assign setup_start = (state == s_stp_start);
   assign eval_start = (state == s_evp_start) || (state == s_evb_start);
   assign eval_block = (instr == poly_cmd_pkg::op_evb);
   assign store_clear = (state == s_rst);
   assign done = (state == s_get_fin) || (state == s_rst) || (state == s_out);
   assign result_valid = (state == s_out) || (state == s_evb_out);

   always_comb
   begin
      result = '0;
      case (instr)
         poly_cmd_pkg::op_stp:
            code = setup_status;
         poly_cmd_pkg::op_evp, poly_cmd_pkg::op_evb:
         begin
            code = eval_status;
            result = eval_result;
         end
         default:
            code = poly_cmd_pkg::st_bad_opcode;
      endcase
   end

   // opcode in the upper half, status code in the lower half
   assign status = {{(poly_cfg_pkg::acc_w - poly_cmd_pkg::op_w - poly_cmd_pkg::code_w){1'b0}},
                    instr, code};

endmodule

//--- logic/poly_actor_top.sv
`timescale 1ns/1ps

module poly_actor_top
(
   input  logic clk,
   input  logic rst,
   input  logic data_push,
   input  logic [poly_cfg_pkg::word_w-1:0] data_token,
   input  logic cmd_push,
   input  logic [poly_cfg_pkg::word_w-1:0] cmd_word,
   input  logic start,
   input  logic [1:0] next_mode,
   output logic done,
   output logic result_valid,
   output logic [poly_cfg_pkg::acc_w-1:0] result,
   output logic [poly_cfg_pkg::acc_w-1:0] status
);

   logic data_avail;
   logic [poly_cfg_pkg::word_w-1:0] data_head;
   logic setup_pop;
   logic eval_pop;
   logic cmd_avail;
   logic cmd_pop;
   logic [poly_cfg_pkg::word_w-1:0] cmd_head;
   logic [poly_cmd_pkg::op_w-1:0] instr;
   logic [poly_cfg_pkg::slot_w-1:0] slot;
   logic [poly_cmd_pkg::cnt_w-1:0] count;
   logic dec_start;
   logic dec_done;
   logic setup_start;
   logic setup_done;
   logic [poly_cmd_pkg::code_w-1:0] setup_status;
   logic eval_start;
   logic eval_block;
   logic eval_point;
   logic eval_done;
   logic [poly_cmd_pkg::code_w-1:0] eval_status;
   logic [poly_cfg_pkg::acc_w-1:0] eval_result;
   logic store_clear;

   coef_bus_if coef_bus ();

   // ##########################################################
   // token queues where the data queue is read by STP and EVP/EVB
   // ##########################################################
   token_queue #(.depth(poly_cfg_pkg::queue_depth)) u_data_q (
      .clk(clk), .rst(rst), .push(data_push), .push_token(data_token),
      .pop_a(setup_pop), .pop_b(eval_pop), .avail(data_avail), .token(data_head));

   token_queue #(.depth(poly_cfg_pkg::queue_depth)) u_cmd_q (
      .clk(clk), .rst(rst), .push(cmd_push), .push_token(cmd_word),
      .pop_a(cmd_pop), .pop_b(1'b0), .avail(cmd_avail), .token(cmd_head));

   coef_store u_store (.clk(clk), .rst(rst), .bus(coef_bus.store), .clear(store_clear));

   command_decoder u_decoder (
      .clk(clk), .rst(rst), .start(dec_start), .clear(store_clear), .cmd_avail(cmd_avail),
      .cmd_pop(cmd_pop), .cmd_token(cmd_head), .instr(instr), .slot(slot), .count(count),
      .done(dec_done));

   poly_setup u_setup (
      .clk(clk), .rst(rst), .start(setup_start), .slot(slot), .count(count),
      .data_avail(data_avail), .data_pop(setup_pop), .data_token(data_head),
      .coef(coef_bus.writer), .status(setup_status), .done(setup_done));

   poly_eval u_eval (
      .clk(clk), .rst(rst), .start(eval_start), .slot(slot), .count(count), .block(eval_block),
      .data_avail(data_avail), .data_pop(eval_pop), .data_token(data_head),
      .coef(coef_bus.reader), .result(eval_result), .status(eval_status),
      .point_done(eval_point), .done(eval_done));

   firing_fsm u_fsm (
      .clk(clk), .rst(rst), .start(start), .next_mode(next_mode), .instr(instr),
      .dec_done(dec_done), .setup_done(setup_done), .eval_point(eval_point),
      .eval_done(eval_done), .setup_status(setup_status), .eval_status(eval_status),
      .eval_result(eval_result), .dec_start(dec_start), .setup_start(setup_start),
      .eval_start(eval_start), .eval_block(eval_block), .store_clear(store_clear),
      .done(done), .result_valid(result_valid), .result(result), .status(status));

endmodule

//--- testbench/poly_actor_tb.sv
`timescale 1ns/1ps

module poly_actor_tb;

   localparam int n_rows = 18;
   localparam int half_period = 50;                 // 100 ns clock

   logic clk;
   logic rst;
   logic data_push;
   logic [poly_cfg_pkg::word_w-1:0] data_token;
   logic cmd_push;
   logic [poly_cfg_pkg::word_w-1:0] cmd_word;
   logic start;
   logic [1:0] next_mode;
   logic done;
   logic result_valid;
   logic [poly_cfg_pkg::acc_w-1:0] result;
   logic [poly_cfg_pkg::acc_w-1:0] status;

   // stimulus table with one row per command
   logic [7:0] row_op [n_rows];
   logic [2:0] row_slot [n_rows];
   logic [4:0] row_count [n_rows];
   int row_ntok [n_rows];
   logic [15:0] row_tok [n_rows][8];
   logic [15:0] row_code [n_rows];
   int rows_built;

   // reference model of the slots and the data queue
   logic [15:0] model_coef [8][8];
   int model_order [8];
   logic [15:0] pending [$];                        // pushed but not yet consumed by the DUT
   logic [31:0] exp_result [$];
   logic [31:0] exp_status [$];
   bit exp_check [$];

   int mismatch_count;
   int failure_count;

   poly_actor_top u_dut (
      .clk(clk), .rst(rst), .data_push(data_push), .data_token(data_token),
      .cmd_push(cmd_push), .cmd_word(cmd_word), .start(start), .next_mode(next_mode),
      .done(done), .result_valid(result_valid), .result(result), .status(status));

   initial
   begin
      clk = 1'b0;
      forever #half_period clk = ~clk;
   end

   // ##########################################################
   // table construction and reference model
   // ##########################################################
   task automatic add_row(input logic [7:0] op, input logic [2:0] slot_sel,
                          input logic [4:0] cnt, input int ntok, input logic [15:0] code);
      logic [31:0] rnd;
      begin
         row_op[rows_built] = op;
         row_slot[rows_built] = slot_sel;
         row_count[rows_built] = cnt;
         row_ntok[rows_built] = ntok;
         row_code[rows_built] = code;
         for (int i = 0; i < ntok; i++)
         begin
            rnd = $urandom();
            row_tok[rows_built][i] = rnd[15:0];     // coefficients and x values alike
         end
         rows_built++;
      end
   endtask

   task automatic build_table();
      begin
         add_row(poly_cmd_pkg::op_stp, 3'd0, 5'd0, 1, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evp, 3'd0, 5'd0, 1, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_stp, 3'd1, 5'd3, 4, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evp, 3'd1, 5'd0, 1, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_stp, 3'd2, 5'd7, 8, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evp, 3'd2, 5'd0, 1, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evb, 3'd1, 5'd5, 5, poly_cmd_pkg::st_ok);
         // this token is left behind and picked up by the next good EVP
         add_row(poly_cmd_pkg::op_stp, 3'd5, 5'd9, 1, poly_cmd_pkg::st_bad_order);
         add_row(poly_cmd_pkg::op_evp, 3'd5, 5'd0, 0, poly_cmd_pkg::st_empty_slot);
         add_row(poly_cmd_pkg::op_evp, 3'd2, 5'd0, 0, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evb, 3'd1, 5'd0, 0, poly_cmd_pkg::st_zero_block);
         add_row(8'h3c, 3'd0, 5'd0, 0, poly_cmd_pkg::st_bad_opcode);
         add_row(poly_cmd_pkg::op_stp, 3'd1, 5'd2, 3, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evp, 3'd1, 5'd0, 1, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_rst, 3'd0, 5'd0, 0, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evp, 3'd2, 5'd0, 0, poly_cmd_pkg::st_empty_slot);
         add_row(poly_cmd_pkg::op_stp, 3'd2, 5'd1, 2, poly_cmd_pkg::st_ok);
         add_row(poly_cmd_pkg::op_evb, 3'd2, 5'd2, 2, poly_cmd_pkg::st_ok);
      end
   endtask

   // acc = acc * x + c[i] from the top coefficient down with 32-bit wraparound
   function automatic logic [31:0] horner(input int slot_sel, input logic [31:0] x);
      logic [31:0] acc;
      begin
         acc = '0;
         for (int i = model_order[slot_sel]; i >= 0; i--)
            acc = acc * x + {16'h0000, model_coef[slot_sel][i]};
         return acc;
      end
   endfunction

   task automatic predict_row(input int r);
      logic [31:0] x;
      logic [31:0] stat;
      int n;
      begin
         stat = {8'h00, row_op[r], row_code[r]};
         if (row_op[r] == poly_cmd_pkg::op_rst)
            n = 0;                                  // RST gives no result word
         else if (row_code[r] != poly_cmd_pkg::st_ok)
         begin
            exp_result.push_back('0);
            exp_status.push_back(stat);
            exp_check.push_back(1'b0);
         end
         else if (row_op[r] == poly_cmd_pkg::op_stp)
         begin
            n = int'(row_count[r]);
            for (int i = n; i >= 0; i--)
               model_coef[row_slot[r]][i] = pending.pop_front();    // highest order first
            model_order[row_slot[r]] = n;
            exp_result.push_back('0);
            exp_status.push_back(stat);
            exp_check.push_back(1'b0);
         end
         else
         begin
            n = (row_op[r] == poly_cmd_pkg::op_evp) ? 1 : int'(row_count[r]);
            for (int k = 0; k < n; k++)
            begin
               x = {16'h0000, pending.pop_front()};
               exp_result.push_back(horner(int'(row_slot[r]), x));
               exp_status.push_back(stat);
               exp_check.push_back(1'b1);
            end
         end
      end
   endtask

   // ##########################################################
   // driving and checking
   // ##########################################################
   task automatic check_result(input int r, input logic [1:0] mode);
      logic [31:0] want_result;
      logic [31:0] want_status;
      bit want_check;
      begin
         if (mode == poly_cmd_pkg::mode_setup)
         begin
            failure_count++;
            $display("row %0d: result_valid pulsed during a SETUP firing", r);
         end
         else if (exp_status.size() == 0)
         begin
            failure_count++;
            $display("row %0d: result_valid pulsed with no result expected", r);
         end
         else
         begin
            want_result = exp_result.pop_front();
            want_status = exp_status.pop_front();
            want_check = exp_check.pop_front();
            if (status !== want_status)
            begin
               mismatch_count++;
               $display("Mismatch at %0t: status expected %h got %h (row %0d)",
                        $time, want_status, status, r);
            end
            if (want_check && result !== want_result)
            begin
               mismatch_count++;
               $display("Mismatch at %0t: result expected %h got %h (row %0d)",
                        $time, want_result, result, r);
            end
         end
      end
   endtask

   task automatic fire(input logic [1:0] mode, input int r);
      logic finished;
      begin
         @(negedge clk);
         next_mode = mode;
         start = 1'b1;
         finished = 1'b0;
         while (!finished)
         begin
            @(negedge clk);
            start = 1'b0;
            if (result_valid)
               check_result(r, mode);
            if (done)
            begin
               finished = 1'b1;
               // a good EVB hands over its last result in the done cycle
               if (mode == poly_cmd_pkg::mode_instr && row_op[r] == poly_cmd_pkg::op_evb &&
                   row_code[r] == poly_cmd_pkg::st_ok && !result_valid)
               begin
                  failure_count++;
                  $display("row %0d: done did not arrive together with the last EVB result",
                           r);
               end
               if (exp_status.size() != 0 && mode == poly_cmd_pkg::mode_instr)
               begin
                  failure_count++;
                  $display("row %0d: done came with %0d results still missing",
                           r, exp_status.size());
                  exp_result.delete();
                  exp_status.delete();
                  exp_check.delete();
               end
            end
         end
      end
   endtask

   task automatic apply_row(input int r);
      begin
         for (int i = 0; i < row_ntok[r]; i++)
         begin
            @(negedge clk);
            data_push = 1'b1;
            data_token = row_tok[r][i];
            pending.push_back(row_tok[r][i]);
         end
         @(negedge clk);
         data_push = 1'b0;
         cmd_push = 1'b1;
         cmd_word = {row_op[r], row_slot[r], row_count[r]};
         @(negedge clk);
         cmd_push = 1'b0;
         predict_row(r);
         fire(poly_cmd_pkg::mode_setup, r);
         fire(poly_cmd_pkg::mode_instr, r);
      end
   endtask

   initial
   begin
      rst = 1'b0;
      start = 1'b0;
      next_mode = poly_cmd_pkg::mode_setup;
      data_push = 1'b0;
      data_token = '0;
      cmd_push = 1'b0;
      cmd_word = '0;
      mismatch_count = 0;
      failure_count = 0;
      rows_built = 0;
      void'($urandom(32'h4adec69b));
      build_table();
      repeat (3) @(negedge clk);
      rst = 1'b1;
      for (int r = 0; r < rows_built; r++)
         apply_row(r);
      repeat (2) @(negedge clk);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count + failure_count == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // stops a firing that never reports done
   initial
   begin
      repeat (n_rows * 400) @(posedge clk);
      $display("watchdog expired after %0d cycles without the table finishing", n_rows * 400);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- sim.f
logic/poly_cfg_pkg.sv
logic/poly_cmd_pkg.sv
logic/coef_bus_if.sv
logic/token_queue.sv
logic/coef_store.sv
logic/command_decoder.sv
logic/poly_setup.sv
logic/poly_eval.sv
logic/firing_fsm.sv
logic/poly_actor_top.sv
testbench/poly_actor_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and search the log for the fail message

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps -f sim.f --top-module poly_actor_tb \
   -Mdir "$build_dir" -o poly_actor_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build_dir/poly_actor_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "TESTBENCH FAILED" "$log_file"; then
   exit 1
fi
exit 0
